//--- bench/interrupt_assertions.sv
module interrupt_assertions (
	input logic iCLOCK,
	input logic inRESET,
	input irq_pkg::ext_req_t ext_req,
	input logic ext_ack,
	input irq_pkg::fault_req_t fault,
	input logic fault_ack,
	input logic waiting,
	input irq_pkg::exc_req_t exc,
	input logic exc_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	// A fault ack goes to the held fault and never comes with a device ack
	one_source_ack: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		fault_ack |-> (fault.active && !ext_ack)
	) else $error("fault_ack without a held fault or together with ext_ack");

	// Request to the exception side holds until it is acknowledged
	active_while_waiting: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(waiting && !exc_ack) |=> (exc_ack || (waiting && exc.active))
	) else $error("exc active dropped while waiting for exc_ack");

	// Device ack needs a device on the bus
	ext_ack_with_request: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		ext_ack |-> ext_req.active
	) else $error("ext_ack without an active external request");

endmodule

// ST_WAIT is the one-valued state
bind interrupt_manager interrupt_assertions u_assertions (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.ext_req(ext_req),
	.ext_ack(ext_ack),
	.fault(fault),
	.fault_ack(fault_ack),
	.waiting(state),
	.exc(exc),
	.exc_ack(exc_ack)
);

//--- bench/tb_interrupt_subsystem.sv
module tb_interrupt_subsystem;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_SOURCES = 8;
	localparam int SEED = 32'hdac0_ba60;
	localparam int T_MIXED = 600;
	localparam int T_BLOCK = 300;
	localparam int T_LOCK = 60;
	localparam int T_ROUNDS = 6 * NUM_SOURCES * 8;
	localparam int CYCLE_LIMIT = 8 + T_MIXED + 2 * T_BLOCK + T_LOCK + T_ROUNDS + 1000;

	logic iCLOCK;
	logic inRESET;
	logic [NUM_SOURCES-1:0] dev_req;
	logic [NUM_SOURCES-1:0] dev_ack;
	logic fault_strobe;
	irq_pkg::irq_num_t fault_num;
	irq_pkg::fi0r_t fault_fi0r;
	logic fault_busy;
	logic fault_overrun;
	irq_pkg::ict_write_t ict;
	logic exc_lock;
	irq_pkg::exc_req_t exc;
	logic exc_ack;

	// Testbench state
	int cycle_count;
	int errors;
	int checks;
	bit dev_on;
	bit continuous;
	bit alu_on;
	bit prev_busy;
	int lock_age;
	bit cfg_valid [64];
	bit cfg_enable [64];
	int ack_count [NUM_SOURCES];
	int total_acks;
	irq_pkg::irq_num_t pend_num [$];
	irq_pkg::fi0r_t pend_fi0r [$];
	irq_pkg::irq_num_t svc_log [$];
	bit svc_valid;
	irq_pkg::irq_num_t svc_num;
	irq_pkg::fi0r_t svc_fi0r;
	int svc_wait;

	interrupt_subsystem #(
		.NUM_SOURCES(NUM_SOURCES)
	) UUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.dev_req(dev_req),
		.dev_ack(dev_ack),
		.fault_strobe(fault_strobe),
		.fault_num(fault_num),
		.fault_fi0r(fault_fi0r),
		.fault_busy(fault_busy),
		.fault_overrun(fault_overrun),
		.ict(ict),
		.exc_lock(exc_lock),
		.exc(exc),
		.exc_ack(exc_ack)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK;
	end

	// Watchdog on the cycle counter
	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge iCLOCK);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic check(string what, logic [31:0] actual, logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, actual,
				expected);
		end
	endtask

	function automatic bit line_enabled(int i);
		return !cfg_valid[i] || cfg_enable[i];
	endfunction

	// Exception side takes one interrupt into service
	task automatic start_service(irq_pkg::irq_num_t num, irq_pkg::fi0r_t fi0r);
		if (svc_valid) begin
			check("second interrupt while one is in service", 32'd1, 32'd0);
		end
		svc_valid = 1'b1;
		svc_num = num;
		svc_fi0r = fi0r;
		svc_wait = int'($urandom % 4);
		svc_log.push_back(num);
	endtask

	// One clock cycle of all models: devices, ALU, exception side
	task automatic step();
		irq_pkg::irq_num_t new_num;
		irq_pkg::fi0r_t new_fi0r;
		@(posedge iCLOCK);
		if (exc_lock) begin
			lock_age++;
		end else begin
			lock_age = 0;
		end
		for (int i = 0; i < NUM_SOURCES; i++) begin
			if (dev_ack[i]) begin
				check("dev_ack to a requesting device", 32'(dev_req[i]), 32'd1);
				check("dev_ack to an enabled line", 32'(line_enabled(i)), 32'd1);
				if (lock_age >= 3) begin
					check("dev_ack while locked", 32'd1, 32'd0);
				end
				ack_count[i]++;
				total_acks++;
				start_service(irq_pkg::irq_num_t'(i), '0);
				dev_req[i] <= 1'b0;
			end else if (!dev_req[i] && dev_on && (continuous || $urandom % 4 == 0)) begin
				dev_req[i] <= 1'b1;
			end
		end
		// Falling busy means the held fault went into service
		if (prev_busy && !fault_busy) begin
			if (lock_age >= 3) begin
				check("fault_busy fell while locked", 32'd1, 32'd0);
			end
			if (pend_num.size() != 0) begin
				start_service(pend_num.pop_front(), pend_fi0r.pop_front());
			end else begin
				check("fault serviced with none pending", 32'd1, 32'd0);
			end
		end
		prev_busy = fault_busy;
		fault_strobe <= 1'b0;
		if (alu_on && !fault_busy && !fault_strobe && $urandom % 6 == 0) begin
			new_num = irq_pkg::irq_num_t'(64 + ($urandom % 64));
			new_fi0r = $urandom;
			fault_num <= new_num;
			fault_fi0r <= new_fi0r;
			fault_strobe <= 1'b1;
			pend_num.push_back(new_num);
			pend_fi0r.push_back(new_fi0r);
		end
		if (exc_ack) begin
			exc_ack <= 1'b0;
		end else if (svc_valid) begin
			if (svc_wait == 0) begin
				check("exc active in service", 32'(exc.active), 32'd1);
				check("exc num", 32'(exc.num), 32'(svc_num));
				check("exc fi0r", exc.fi0r, svc_fi0r);
				exc_ack <= 1'b1;
				svc_valid = 1'b0;
			end else begin
				svc_wait--;
			end
		end
	endtask

	task automatic write_entry(int entry, bit enable, bit valid);
		ict <= '{strobe: 1'b1, entry: irq_pkg::dev_num_t'(entry), enable: enable,
			valid: valid};
		step();
		ict <= '0;
		cfg_enable[entry] = enable;
		cfg_valid[entry] = valid;
	endtask

	task automatic check_idle_outputs(string when);
		check({"dev_ack ", when}, 32'(dev_ack), 32'd0);
		check({"fault_busy ", when}, 32'(fault_busy), 32'd0);
		check({"fault_overrun ", when}, 32'(fault_overrun), 32'd0);
		check({"exc active ", when}, 32'(exc.active), 32'd0);
	endtask

	task automatic wait_faults_done();
		while (pend_num.size() != 0 || fault_strobe) begin
			step();
		end
	endtask

	initial begin
		int mark;
		void'($urandom(SEED));
		inRESET = 1'b0;
		dev_req = '0;
		fault_strobe = 1'b0;
		fault_num = '0;
		fault_fi0r = '0;
		ict = '0;
		exc_lock = 1'b0;
		exc_ack = 1'b0;
		for (int i = 0; i < 64; i++) begin
			cfg_valid[i] = 1'b0;
			cfg_enable[i] = 1'b0;
		end

		// Reset state
		repeat (8) begin
			step();
			check_idle_outputs("during reset");
		end
		inRESET <= 1'b1;
		step();
		check_idle_outputs("after reset");

		// Mixed random traffic
		dev_on = 1'b1;
		alu_on = 1'b1;
		repeat (T_MIXED) step();

		// Fault wins over a latched device request
		alu_on = 1'b0;
		wait_faults_done();
		exc_lock <= 1'b1;
		repeat (10) step();
		fault_num <= irq_pkg::irq_num_t'(64 + 21);
		fault_fi0r <= 32'h5a5a_0f0f;
		fault_strobe <= 1'b1;
		pend_num.push_back(irq_pkg::irq_num_t'(64 + 21));
		pend_fi0r.push_back(32'h5a5a_0f0f);
		repeat (4) step();
		mark = svc_log.size();
		exc_lock <= 1'b0;
		while (svc_log.size() == mark) step();
		check("fault served before devices", 32'(svc_log[mark] >= 64), 32'd1);

		// Fairness with every device requesting
		alu_on = 1'b1;
		continuous = 1'b1;
		mark = total_acks;
		while (total_acks < mark + 2) step();
		repeat (4) begin
			for (int i = 0; i < NUM_SOURCES; i++) ack_count[i] = 0;
			mark = total_acks;
			while (total_acks < mark + NUM_SOURCES) step();
			for (int i = 0; i < NUM_SOURCES; i++) begin
				check("acks per round", 32'(ack_count[i]), 32'd1);
			end
		end

		// Block lines 2 and 5 once the devices are quiet
		continuous = 1'b0;
		dev_on = 1'b0;
		while (dev_req != '0) step();
		repeat (4) step();
		write_entry(2, 1'b0, 1'b1);
		write_entry(5, 1'b0, 1'b1);
		for (int i = 0; i < NUM_SOURCES; i++) ack_count[i] = 0;
		dev_on = 1'b1;
		repeat (T_BLOCK) step();
		check("acks of blocked line 2", 32'(ack_count[2]), 32'd0);
		check("acks of blocked line 5", 32'(ack_count[5]), 32'd0);
		check("line 0 still served", 32'(ack_count[0] > 0), 32'd1);
		write_entry(2, 1'b0, 1'b0);
		for (int i = 0; i < NUM_SOURCES; i++) ack_count[i] = 0;
		repeat (T_BLOCK) step();
		check("line 2 served again", 32'(ack_count[2] > 0), 32'd1);

		// Overrun, second report is lost
		alu_on = 1'b0;
		wait_faults_done();
		exc_lock <= 1'b1;
		step();
		check("fault_overrun before overrun", 32'(fault_overrun), 32'd0);
		fault_num <= irq_pkg::irq_num_t'(64 + 3);
		fault_fi0r <= 32'h0000_1234;
		fault_strobe <= 1'b1;
		pend_num.push_back(irq_pkg::irq_num_t'(64 + 3));
		pend_fi0r.push_back(32'h0000_1234);
		step();
		fault_num <= irq_pkg::irq_num_t'(64 + 44);
		fault_fi0r <= 32'hdead_0044;
		fault_strobe <= 1'b1;
		repeat (3) step();
		check("fault_overrun after overrun", 32'(fault_overrun), 32'd1);
		check("fault_busy holds first report", 32'(fault_busy), 32'd1);
		exc_lock <= 1'b0;
		wait_faults_done();

		// Lock holds off all service
		alu_on = 1'b1;
		exc_lock <= 1'b1;
		repeat (T_LOCK) step();
		mark = total_acks;
		exc_lock <= 1'b0;
		while (total_acks == mark) step();
		alu_on = 1'b0;
		dev_on = 1'b0;
		wait_faults_done();
		repeat (20) step();
		check("fault_overrun stays set", 32'(fault_overrun), 32'd1);

		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_count);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- hw/fault_capture.sv
module fault_capture (
	input logic iCLOCK,
	input logic inRESET,
	// Single-cycle report from the ALU
	input logic fault_strobe,
	input irq_pkg::irq_num_t fault_num,
	input irq_pkg::fi0r_t fault_fi0r,
	// Held fault towards the manager
	output irq_pkg::fault_req_t fault,
	input logic fault_ack,
	output logic fault_overrun
);

	logic held_active;
	irq_pkg::irq_num_t held_num;
	irq_pkg::fi0r_t held_fi0r;

	// Entry state and sticky overrun
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			held_active <= 1'b0;
			fault_overrun <= 1'b0;
		end else begin
			if (held_active) begin
				if (fault_ack) begin
					held_active <= 1'b0;
				end
				// Report while full is lost
				if (fault_strobe) begin
					fault_overrun <= 1'b1;
				end
			end else if (fault_strobe) begin
				held_active <= 1'b1;
			end
		end
	end

	// Payload only loads into an empty entry
	always_ff @(posedge iCLOCK) begin
		if (fault_strobe && !held_active) begin
			held_num <= fault_num;
			held_fi0r <= fault_fi0r;
		end
	end

	assign fault = '{
		active: held_active,
		num: held_num,
		fi0r: held_fi0r
	};

endmodule

//--- hw/interrupt_manager.sv
`include "irq_defs.svh"

module interrupt_manager (
	input logic iCLOCK,
	input logic inRESET,
	// Configuration table write port
	input irq_pkg::ict_write_t ict,
	// Device side
	input irq_pkg::ext_req_t ext_req,
	output logic ext_ack,
	output logic ext_reject,
	// Fault side
	input irq_pkg::fault_req_t fault,
	output logic fault_ack,
	// Exception side
	input logic exc_lock,
	output irq_pkg::exc_req_t exc,
	input logic exc_ack
);

	typedef enum logic {
		ST_IDLE,
		ST_WAIT
	} state_t;

	// Per-line configuration
	logic ict_enable [irq_pkg::ICT_ENTRIES];
	logic ict_valid [irq_pkg::ICT_ENTRIES];

	// Hardware request latch
	logic hw_valid;
	irq_pkg::dev_num_t hw_num;

	// Dispatch state
	state_t state;
	irq_pkg::irq_num_t irq_num;
	irq_pkg::fi0r_t irq_fi0r;
	logic irq_is_hw;
	logic ack_pulse;

	logic line_enabled;
	logic latch_open;
	logic dispatch_ok;
	logic take_fault;
	logic take_hw;
	logic exc_active;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < irq_pkg::ICT_ENTRIES; i++) begin
				ict_valid[i] <= 1'b0;
			end
			if (`DATA_RESET_ENABLE) begin
				for (int i = 0; i < irq_pkg::ICT_ENTRIES; i++) begin
					ict_enable[i] <= 1'b0;
				end
			end
		end else if (ict.strobe) begin
			ict_enable[ict.entry] <= ict.enable;
			ict_valid[ict.entry] <= ict.valid;
		end
	end

	// Invalid entries pass everything, valid ones follow the enable bit
	assign line_enabled = !ict_valid[ext_req.num] || ict_enable[ext_req.num];

	// The acked request is still on the bus during ext_ack, keep it out
	assign latch_open = !hw_valid && !ext_ack;
	assign ext_reject = latch_open && ext_req.active && !line_enabled;

	assign dispatch_ok = (state == ST_IDLE) && !exc_lock;
	// Faults win over device interrupts
	assign take_fault = dispatch_ok && fault.active;
	assign take_hw = dispatch_ok && !fault.active && hw_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hw_valid <= 1'b0;
			if (`DATA_RESET_ENABLE) begin
				hw_num <= '0;
			end
		end else if (latch_open) begin
			if (ext_req.active && line_enabled) begin
				hw_valid <= 1'b1;
				hw_num <= ext_req.num;
			end
		end else if (take_hw) begin
			hw_valid <= 1'b0;
		end
	end

	// Dispatch FSM, one interrupt out until exc_ack
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
			irq_is_hw <= 1'b0;
			ack_pulse <= 1'b0;
			if (`DATA_RESET_ENABLE) begin
				irq_num <= '0;
				irq_fi0r <= '0;
			end
		end else begin
			case (state)
				ST_IDLE: begin
					if (take_fault) begin
						state <= ST_WAIT;
						irq_num <= fault.num;
						irq_fi0r <= fault.fi0r;
						irq_is_hw <= 1'b0;
						ack_pulse <= 1'b1;
					end else if (take_hw) begin
						state <= ST_WAIT;
						irq_num <= irq_pkg::irq_num_t'(hw_num);
						// Devices carry no fault info
						irq_fi0r <= '0;
						irq_is_hw <= 1'b1;
						ack_pulse <= 1'b1;
					end
				end
				ST_WAIT: begin
					ack_pulse <= 1'b0;
					if (exc_ack) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// Source ack in the first waiting cycle
	assign ext_ack = ack_pulse && irq_is_hw;
	assign fault_ack = ack_pulse && !irq_is_hw;

	// Waiting: high until exc_ack, idle: high when something can go out
	assign exc_active = (state == ST_WAIT) ? !exc_ack
		: (!exc_lock && (fault.active || hw_valid));

	assign exc = '{
		active: exc_active,
		num: irq_num,
		fi0r: irq_fi0r
	};

endmodule

//--- hw/interrupt_subsystem.sv
module interrupt_subsystem #(
	parameter int NUM_SOURCES = 8
) (
	input logic iCLOCK,
	input logic inRESET,
	// Peripheral devices
	input logic [NUM_SOURCES-1:0] dev_req,
	output logic [NUM_SOURCES-1:0] dev_ack,
	// ALU fault reports
	input logic fault_strobe,
	input irq_pkg::irq_num_t fault_num,
	input irq_pkg::fi0r_t fault_fi0r,
	output logic fault_busy,
	output logic fault_overrun,
	// Configuration table
	input irq_pkg::ict_write_t ict,
	// Exception side
	input logic exc_lock,
	output irq_pkg::exc_req_t exc,
	input logic exc_ack
);

	irq_pkg::ext_req_t ext_req;
	logic ext_ack;
	logic ext_reject;
	irq_pkg::fault_req_t fault;
	logic fault_ack;

	irq_source_arbiter #(
		.NUM_SOURCES(NUM_SOURCES)
	) u_arbiter (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.dev_req(dev_req),
		.dev_ack(dev_ack),
		.ext_req(ext_req),
		.ext_ack(ext_ack),
		.ext_reject(ext_reject)
	);

	fault_capture u_fault_capture (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.fault_strobe(fault_strobe),
		.fault_num(fault_num),
		.fault_fi0r(fault_fi0r),
		.fault(fault),
		.fault_ack(fault_ack),
		.fault_overrun(fault_overrun)
	);

	// Busy while a fault is held
	assign fault_busy = fault.active;

	interrupt_manager u_manager (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.ict(ict),
		.ext_req(ext_req),
		.ext_ack(ext_ack),
		.ext_reject(ext_reject),
		.fault(fault),
		.fault_ack(fault_ack),
		.exc_lock(exc_lock),
		.exc(exc),
		.exc_ack(exc_ack)
	);

endmodule

//--- hw/irq_pkg.sv
package irq_pkg;

	// Widths of the interrupt front end
	localparam int DEV_NUM_W = 6;
	localparam int IRQ_NUM_W = 7;
	localparam int FI0R_W = 32;
	localparam int ICT_ENTRIES = 1 << DEV_NUM_W;

	// Device line number, 0 to 63
	typedef logic [DEV_NUM_W-1:0] dev_num_t;

	// Interrupt number, bit 6 set for faults
	typedef logic [IRQ_NUM_W-1:0] irq_num_t;

	typedef logic [FI0R_W-1:0] fi0r_t;

	// Shared external-request bus from the arbiter
	typedef struct packed {
		logic active;
		dev_num_t num;
	} ext_req_t;

	// Fault report held for the manager
	typedef struct packed {
		logic active;
		irq_num_t num;
		fi0r_t fi0r;
	} fault_req_t;

	// One configuration table write
	typedef struct packed {
		logic strobe;
		dev_num_t entry;
		logic enable;
		logic valid;
	} ict_write_t;

	// Request towards the exception side
	typedef struct packed {
		logic active;
		irq_num_t num;
		fi0r_t fi0r;
	} exc_req_t;

endpackage

//--- hw/irq_source_arbiter.sv
module irq_source_arbiter #(
	parameter int NUM_SOURCES = 8
) (
	input logic iCLOCK,
	input logic inRESET,
	// Level requests, one per device
	input logic [NUM_SOURCES-1:0] dev_req,
	output logic [NUM_SOURCES-1:0] dev_ack,
	// Shared bus towards the manager
	output irq_pkg::ext_req_t ext_req,
	input logic ext_ack,
	input logic ext_reject
);

	localparam int IDX_W = $clog2(NUM_SOURCES);

	logic grant_active;
	logic [IDX_W-1:0] owner;
	logic found;
	logic [IDX_W-1:0] next_owner;

	// Round-robin search, starts one past the last owner
	always_comb begin
		int cand;
		found = 1'b0;
		next_owner = owner;
		for (int k = 1; k <= NUM_SOURCES; k++) begin
			cand = (int'(owner) + k) % NUM_SOURCES;
			if (!found && dev_req[cand]) begin
				found = 1'b1;
				next_owner = IDX_W'(cand);
			end
		end
	end

	// Grant is held until the manager acks or rejects it
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			grant_active <= 1'b0;
			// Point at the last device so device 0 wins first
			owner <= IDX_W'(NUM_SOURCES - 1);
		end else if (grant_active) begin
			if (ext_ack || ext_reject) begin
				grant_active <= 1'b0;
			end
		end else if (found) begin
			grant_active <= 1'b1;
			owner <= next_owner;
		end
	end

	// Owner sees its ack in the same cycle as ext_ack
	always_comb begin
		for (int i = 0; i < NUM_SOURCES; i++) begin
			dev_ack[i] = grant_active && ext_ack && (owner == IDX_W'(i));
		end
	end

	// A rejected owner gets no dev_ack and is revisited next round
	assign ext_req = '{
		active: grant_active,
		num: irq_pkg::dev_num_t'(owner)
	};

endmodule

//--- include/irq_defs.svh
`ifndef IRQ_DEFS_SVH
`define IRQ_DEFS_SVH

// Clear table data and number registers on reset
// 1'b0 leaves them at their power-up value
`define DATA_RESET_ENABLE 1'b1

`endif

//--- run.sh
#!/bin/sh
# Build and run the interrupt subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/sim_tb_interrupt_subsystem

verilator --binary --timing --assert -f tb.f \
	--top-module tb_interrupt_subsystem \
	-o sim_tb_interrupt_subsystem > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see $BUILD_LOG"
	exit 1
fi

"$SIM_BIN" > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see $SIM_LOG"
	exit 1
fi

if grep -q "TESTBENCH PASSED" "$SIM_LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation did not pass, see $SIM_LOG"
exit 1

//--- tb.f
+incdir+include
hw/irq_pkg.sv
hw/irq_source_arbiter.sv
hw/fault_capture.sv
hw/interrupt_manager.sv
hw/interrupt_subsystem.sv
bench/interrupt_assertions.sv
bench/tb_interrupt_subsystem.sv
